/* cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// ----------------------------------------------------------
// core wide widths
// ----------------------------------------------------------

// data and address word
`define CPU_WORD_W 32

// register index, 32 registers
`define CPU_REG_AW 5

// ----------------------------------------------------------
// reset values
// ----------------------------------------------------------

`define CPU_PC_INIT 32'h0000_0000  // first fetch address

`endif

/* cpu_types_pkg.sv */
`include "cpu_macros.svh"

package cpu_types_pkg;

  typedef logic [`CPU_WORD_W-1:0] word_t;
  typedef logic [`CPU_REG_AW-1:0] regbits_t;

  // ----------------------------------------------------------
  // instruction encodings
  // ----------------------------------------------------------
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    JAL   = 6'b000011,
    BEQ   = 6'b000100,
    BNE   = 6'b000101,
    ADDIU = 6'b001001,
    ORI   = 6'b001101,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011,
    HALT  = 6'b111111
  } opcode_t;

  typedef enum logic [5:0] {
    JR   = 6'b001000,
    ADDU = 6'b100001,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    SLT  = 6'b101010
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,  // zero value, so a bubble adds
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } aluop_t;

  typedef enum logic [1:0] {
    FWD_NONE = 2'd0,
    FWD_MEM  = 2'd1,
    FWD_WB   = 2'd2
  } fwd_sel_t;

  // decoded control, all zero is a bubble
  typedef struct packed {
    logic   RegWr;
    logic   RegDst;
    logic   ALUSrc;
    logic   ExtOp;
    logic   MemtoReg;
    logic   dREN;
    logic   dWEN;
    logic   beq;
    logic   bne;
    logic   jump;
    logic   jal;
    logic   jr;
    logic   lui;
    logic   halt;
    aluop_t aluop;
  } ctrl_t;

  // ----------------------------------------------------------
  // pipeline latches
  // ----------------------------------------------------------
  typedef struct packed {
    word_t instr;
    word_t pc;
    word_t pcplusfour;
  } fd_t;

  typedef struct packed {
    word_t    instr;
    word_t    pc;
    word_t    pcplusfour;
    ctrl_t    ctrl;
    word_t    rdat1;
    word_t    rdat2;
    word_t    imm;   // already extended
    regbits_t wsel;
  } de_t;

  typedef struct packed {
    word_t    instr;
    word_t    pc;
    word_t    pcplusfour;
    ctrl_t    ctrl;
    word_t    rdat1;  // forwarded rs, jr target
    word_t    rdat2;  // forwarded rt, store data
    word_t    imm;
    regbits_t wsel;
    word_t    alu_out;
    logic     zero;
  } em_t;

  typedef struct packed {
    word_t    instr;
    word_t    pc;
    word_t    pcplusfour;
    ctrl_t    ctrl;
    regbits_t wsel;
    word_t    alu_out;
    word_t    dload;
  } mw_t;

endpackage

/* register_file_if.sv */
`timescale 1ns/1ps

interface register_file_if import cpu_types_pkg::*; ();

  // read side, decode stage
  regbits_t rsel1;
  regbits_t rsel2;
  word_t    rdat1;
  word_t    rdat2;

  // write side, writeback stage
  regbits_t wsel;
  word_t    wdat;
  logic     WEN;

  modport dp (
    output rsel1, rsel2, wsel, wdat, WEN,
    input  rdat1, rdat2
  );

  modport rf (
    input  rsel1, rsel2, wsel, wdat, WEN,
    output rdat1, rdat2
  );

endinterface

/* register_file.sv */
`timescale 1ns/1ps

module register_file import cpu_types_pkg::*; (
  input logic         CLK,
  input logic         nRST,
  register_file_if.rf rfif
);

  word_t regs [32];
  logic  wr_live;

  // r0 never written, so it reads zero
  assign wr_live = rfif.WEN && (rfif.wsel != '0);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      regs <= '{default: '0};
    end else if (wr_live) begin
      regs[rfif.wsel] <= rfif.wdat;
    end
  end

  // write bypass, decode sees this cycle's writeback
  always_comb begin
    rfif.rdat1 = regs[rfif.rsel1];
    rfif.rdat2 = regs[rfif.rsel2];
    if (wr_live && (rfif.wsel == rfif.rsel1)) begin
      rfif.rdat1 = rfif.wdat;
    end
    if (wr_live && (rfif.wsel == rfif.rsel2)) begin
      rfif.rdat2 = rfif.wdat;
    end
  end

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu import cpu_types_pkg::*; (
  input  aluop_t op,
  input  word_t  port_a,
  input  word_t  port_b,
  output word_t  result,
  output logic   zero
);

  always_comb begin
    case (op)
      ALU_ADD: begin
        result = port_a + port_b;
      end
      ALU_SUB: begin
        result = port_a - port_b;  // also the beq/bne compare
      end
      ALU_AND: begin
        result = port_a & port_b;
      end
      ALU_OR: begin
        result = port_a | port_b;
      end
      ALU_SLT: begin
        // signed compare
        result = ($signed(port_a) < $signed(port_b)) ? word_t'(1) : '0;
      end
      default: begin
        result = '0;
      end
    endcase
  end

  assign zero = (result == '0);

endmodule

/* control_unit.sv */
`timescale 1ns/1ps

module control_unit import cpu_types_pkg::*; (
  input  word_t instr,
  output ctrl_t ctrl
);

  opcode_t op;
  funct_t  fn;

  assign op = opcode_t'(instr[31:26]);
  assign fn = funct_t'(instr[5:0]);

  always_comb begin
    ctrl = '0;  // unknown encodings stay a bubble
    case (op)
      RTYPE: begin
        ctrl.RegDst = 1'b1;
        case (fn)
          ADDU: begin
            ctrl.RegWr = 1'b1;
            ctrl.aluop = ALU_ADD;
          end
          SUBU: begin
            ctrl.RegWr = 1'b1;
            ctrl.aluop = ALU_SUB;
          end
          AND: begin
            ctrl.RegWr = 1'b1;
            ctrl.aluop = ALU_AND;
          end
          OR: begin
            ctrl.RegWr = 1'b1;
            ctrl.aluop = ALU_OR;
          end
          SLT: begin
            ctrl.RegWr = 1'b1;
            ctrl.aluop = ALU_SLT;
          end
          JR: begin
            ctrl.jr = 1'b1;  // target is rs, no write
          end
          default: begin
            ctrl = '0;
          end
        endcase
      end
      ADDIU: begin
        ctrl.RegWr  = 1'b1;
        ctrl.ALUSrc = 1'b1;
        ctrl.ExtOp  = 1'b1;
      end
      ORI: begin
        ctrl.RegWr  = 1'b1;
        ctrl.ALUSrc = 1'b1;  // zero extended
        ctrl.aluop  = ALU_OR;
      end
      LUI: begin
        ctrl.RegWr  = 1'b1;
        ctrl.ALUSrc = 1'b1;
        ctrl.lui    = 1'b1;
      end
      LW: begin
        ctrl.RegWr    = 1'b1;
        ctrl.ALUSrc   = 1'b1;
        ctrl.ExtOp    = 1'b1;
        ctrl.MemtoReg = 1'b1;
        ctrl.dREN     = 1'b1;
      end
      SW: begin
        ctrl.ALUSrc = 1'b1;
        ctrl.ExtOp  = 1'b1;
        ctrl.dWEN   = 1'b1;
      end
      BEQ, BNE: begin
        ctrl.beq   = (op == BEQ);
        ctrl.bne   = (op == BNE);
        ctrl.ExtOp = 1'b1;
        ctrl.aluop = ALU_SUB;
      end
      J: begin
        ctrl.jump = 1'b1;
      end
      JAL: begin
        ctrl.jal   = 1'b1;
        ctrl.RegWr = 1'b1;  // r31 picked in decode
      end
      HALT: begin
        ctrl.halt = 1'b1;
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

/* hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit import cpu_types_pkg::*; (
  input  regbits_t fd_rs,
  input  regbits_t fd_rt,
  input  de_t      de,
  input  em_t      em,
  input  mw_t      mw,
  input  logic     taken,
  output logic     stall,
  output logic     flush,
  output fwd_sel_t fwd_a,
  output fwd_sel_t fwd_b
);

  regbits_t ex_rs;
  regbits_t ex_rt;
  logic     mem_wr;
  logic     wb_wr;

  // source registers of the instruction in execute
  assign ex_rs = de.instr[25:21];
  assign ex_rt = de.instr[20:16];

  // ----------------------------------------------------------
  // load-use and control hazards
  // ----------------------------------------------------------

  // load result only exists after the memory stage
  assign stall = de.ctrl.dREN && (de.wsel != '0) &&
                 ((de.wsel == fd_rs) || (de.wsel == fd_rt));

  assign flush = taken;  // redirect from memory stage

  // ----------------------------------------------------------
  // forwarding
  // ----------------------------------------------------------
  assign mem_wr = em.ctrl.RegWr && (em.wsel != '0);
  assign wb_wr  = mw.ctrl.RegWr && (mw.wsel != '0);

  // nearer stage wins
  always_comb begin
    fwd_a = FWD_NONE;
    if (mem_wr && (em.wsel == ex_rs)) begin
      fwd_a = FWD_MEM;
    end else if (wb_wr && (mw.wsel == ex_rs)) begin
      fwd_a = FWD_WB;
    end
  end

  always_comb begin
    fwd_b = FWD_NONE;
    if (mem_wr && (em.wsel == ex_rt)) begin
      fwd_b = FWD_MEM;
    end else if (wb_wr && (mw.wsel == ex_rt)) begin
      fwd_b = FWD_WB;
    end
  end

endmodule

/* datapath.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module datapath import cpu_types_pkg::*; #(
  parameter word_t PC_INIT = `CPU_PC_INIT
) (
  input  logic        CLK,
  input  logic        nRST,
  register_file_if.dp rfif,
  input  word_t       imemload,
  input  logic        ihit,
  input  word_t       dmemload,
  input  logic        dhit,
  output logic        imemREN,
  output word_t       imemaddr,
  output logic        dmemREN,
  output logic        dmemWEN,
  output word_t       dmemaddr,
  output word_t       dmemstore,
  output logic        halt
);

  word_t    pc;
  word_t    pc_plus4;
  word_t    next_target;
  logic     fetch_on;   // low for the first cycle after reset
  logic     en;         // pipeline advance
  logic     stall;
  logic     flush;
  logic     taken;
  logic     halt_any;
  logic     dmem_req;
  fd_t      fd;
  de_t      de;
  em_t      em;
  mw_t      mw;
  fd_t      fd_next;
  de_t      de_next;
  em_t      em_next;
  mw_t      mw_next;
  ctrl_t    dec_ctrl;
  word_t    ext_imm;
  regbits_t dec_wsel;
  fwd_sel_t fwd_a;
  fwd_sel_t fwd_b;
  word_t    opnd_a;
  word_t    opnd_b;
  word_t    alu_b;
  word_t    alu_res;
  logic     alu_zero;
  word_t    wb_dat;

  control_unit u_cu (
    .instr (fd.instr),
    .ctrl  (dec_ctrl)
  );

  alu u_alu (
    .op     (de.ctrl.aluop),
    .port_a (opnd_a),
    .port_b (alu_b),
    .result (alu_res),
    .zero   (alu_zero)
  );

  hazard_unit u_hu (
    .fd_rs (fd.instr[25:21]),
    .fd_rt (fd.instr[20:16]),
    .de    (de),
    .em    (em),
    .mw    (mw),
    .taken (taken),
    .stall (stall),
    .flush (flush),
    .fwd_a (fwd_a),
    .fwd_b (fwd_b)
  );

  // ----------------------------------------------------------
  // memory handshake and advance
  // ----------------------------------------------------------
  assign halt_any = halt | mw.ctrl.halt;  // covers the cycle before halt rises
  assign dmem_req = (em.ctrl.dREN | em.ctrl.dWEN) & ~halt_any;

  assign imemREN   = fetch_on & ~halt;
  assign imemaddr  = pc;
  assign dmemREN   = em.ctrl.dREN & ~halt_any;
  assign dmemWEN   = em.ctrl.dWEN & ~halt_any;
  assign dmemaddr  = em.alu_out;
  assign dmemstore = em.rdat2;

  assign en = ihit & imemREN & (~dmem_req | dhit);

  // fetch
  assign pc_plus4 = pc + 4;

  always_comb begin
    fd_next.instr      = imemload;
    fd_next.pc         = pc;
    fd_next.pcplusfour = pc_plus4;
  end

  // ----------------------------------------------------------
  // decode
  // ----------------------------------------------------------
  assign rfif.rsel1 = fd.instr[25:21];
  assign rfif.rsel2 = fd.instr[20:16];

  assign ext_imm = dec_ctrl.ExtOp ? {{16{fd.instr[15]}}, fd.instr[15:0]}
                                  : {16'h0000, fd.instr[15:0]};

  always_comb begin
    if (dec_ctrl.jal) begin
      dec_wsel = '1;  // r31
    end else if (dec_ctrl.RegDst) begin
      dec_wsel = fd.instr[15:11];
    end else begin
      dec_wsel = fd.instr[20:16];
    end
  end

  always_comb begin
    de_next.instr      = fd.instr;
    de_next.pc         = fd.pc;
    de_next.pcplusfour = fd.pcplusfour;
    de_next.ctrl       = dec_ctrl;
    de_next.rdat1      = rfif.rdat1;
    de_next.rdat2      = rfif.rdat2;
    de_next.imm        = ext_imm;
    de_next.wsel       = dec_wsel;
  end

  // ----------------------------------------------------------
  // execute
  // ----------------------------------------------------------
  always_comb begin
    case (fwd_a)
      FWD_MEM: opnd_a = em.alu_out;
      FWD_WB:  opnd_a = wb_dat;
      default: opnd_a = de.rdat1;
    endcase
    case (fwd_b)
      FWD_MEM: opnd_b = em.alu_out;
      FWD_WB:  opnd_b = wb_dat;
      default: opnd_b = de.rdat2;
    endcase
  end

  assign alu_b = de.ctrl.ALUSrc ? de.imm : opnd_b;

  always_comb begin
    em_next.instr      = de.instr;
    em_next.pc         = de.pc;
    em_next.pcplusfour = de.pcplusfour;
    em_next.ctrl       = de.ctrl;
    em_next.rdat1      = opnd_a;
    em_next.rdat2      = opnd_b;
    em_next.imm        = de.imm;
    em_next.wsel       = de.wsel;
    em_next.zero       = alu_zero;
    // lui bypasses the alu
    em_next.alu_out    = de.ctrl.lui ? {de.instr[15:0], 16'h0000} : alu_res;
  end

  // memory stage, branch resolution
  assign taken = em.ctrl.jump | em.ctrl.jal | em.ctrl.jr |
                 (em.ctrl.beq & em.zero) | (em.ctrl.bne & ~em.zero);

  always_comb begin
    if (em.ctrl.jr) begin
      next_target = em.rdat1;
    end else if (em.ctrl.jump | em.ctrl.jal) begin
      next_target = {em.pcplusfour[`CPU_WORD_W-1 -: 4], em.instr[25:0], 2'b00};
    end else begin
      next_target = em.pcplusfour + {em.imm[29:0], 2'b00};
    end
  end

  always_comb begin
    mw_next.instr      = em.instr;
    mw_next.pc         = em.pc;
    mw_next.pcplusfour = em.pcplusfour;
    mw_next.ctrl       = em.ctrl;
    mw_next.wsel       = em.wsel;
    mw_next.alu_out    = em.alu_out;
    mw_next.dload      = dmemload;  // valid on the advancing edge
  end

  // writeback
  always_comb begin
    if (mw.ctrl.jal) begin
      wb_dat = mw.pcplusfour;
    end else if (mw.ctrl.MemtoReg) begin
      wb_dat = mw.dload;
    end else begin
      wb_dat = mw.alu_out;
    end
  end

  assign rfif.WEN  = mw.ctrl.RegWr;
  assign rfif.wsel = mw.wsel;
  assign rfif.wdat = wb_dat;

  // ----------------------------------------------------------
  // state
  // ----------------------------------------------------------
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      fetch_on <= 1'b0;
      halt     <= 1'b0;
    end else begin
      fetch_on <= 1'b1;
      halt     <= halt | mw.ctrl.halt;  // sticky
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc <= PC_INIT;
      fd <= '0;
      de <= '0;
      em <= '0;
      mw <= '0;
    end else if (en) begin
      mw <= mw_next;
      if (flush) begin
        pc <= next_target;
        fd <= '0;
        de <= '0;
        em <= '0;
      end else begin
        em <= em_next;
        if (stall) begin
          de <= '0;  // bubble, pc and fd hold
        end else begin
          pc <= pc_plus4;
          fd <= fd_next;
          de <= de_next;
        end
      end
    end
  end

endmodule

/* cpu_core.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_core import cpu_types_pkg::*; #(
  parameter word_t PC_INIT = `CPU_PC_INIT
) (
  input  logic  CLK,
  input  logic  nRST,
  input  word_t imemload,
  input  logic  ihit,
  input  word_t dmemload,
  input  logic  dhit,
  output logic  imemREN,
  output word_t imemaddr,
  output logic  dmemREN,
  output logic  dmemWEN,
  output word_t dmemaddr,
  output word_t dmemstore,
  output logic  halt
);

  register_file_if rfif ();

  datapath #(
    .PC_INIT (PC_INIT)
  ) u_dp (
    .CLK       (CLK),
    .nRST      (nRST),
    .rfif      (rfif.dp),
    .imemload  (imemload),
    .ihit      (ihit),
    .dmemload  (dmemload),
    .dhit      (dhit),
    .imemREN   (imemREN),
    .imemaddr  (imemaddr),
    .dmemREN   (dmemREN),
    .dmemWEN   (dmemWEN),
    .dmemaddr  (dmemaddr),
    .dmemstore (dmemstore),
    .halt      (halt)
  );

  register_file u_rf (
    .CLK  (CLK),
    .nRST (nRST),
    .rfif (rfif.rf)
  );

endmodule

/* cpu_asserts.sv */
`timescale 1ns/1ps

module cpu_asserts import cpu_types_pkg::*; (
  input logic  CLK,
  input logic  nRST,
  input logic  imemREN,
  input logic  dmemREN,
  input logic  dmemWEN,
  input word_t dmemaddr,
  input word_t dmemstore,
  input logic  dhit,
  input logic  halt
);

  int fail_count = 0;

  // data request held until its hit
  a_dreq_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (dmemREN || dmemWEN) && !dhit |=>
      $stable(dmemREN) && $stable(dmemWEN) && $stable(dmemaddr) && $stable(dmemstore))
    else begin
      $error("data request changed before dhit");
      fail_count++;
    end

  a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
    else begin
      $error("halt fell without reset");
      fail_count++;
    end

  a_rw_excl: assert property (@(posedge CLK) disable iff (!nRST) !(dmemREN && dmemWEN))
    else begin
      $error("dmemREN and dmemWEN high together");
      fail_count++;
    end

  // nothing leaves the core once halted
  a_quiet_halt: assert property (@(posedge CLK) disable iff (!nRST)
    halt |-> !imemREN && !dmemREN && !dmemWEN)
    else begin
      $error("memory request while halted");
      fail_count++;
    end

endmodule

bind cpu_core cpu_asserts u_asserts (
  .CLK       (CLK),
  .nRST      (nRST),
  .imemREN   (imemREN),
  .dmemREN   (dmemREN),
  .dmemWEN   (dmemWEN),
  .dmemaddr  (dmemaddr),
  .dmemstore (dmemstore),
  .dhit      (dhit),
  .halt      (halt)
);

/* cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb import cpu_types_pkg::*; ();

  localparam int CLK_PERIOD      = 4;
  localparam int N_TESTS         = 6;
  localparam int CYCLES_PER_TEST = 200;
  localparam logic [31:0] SEED   = 32'heeb46ccd;

  logic  CLK;
  logic  nRST;
  word_t imemload;
  logic  ihit;
  word_t dmemload;
  logic  dhit;
  logic  imemREN;
  word_t imemaddr;
  logic  dmemREN;
  logic  dmemWEN;
  word_t dmemaddr;
  word_t dmemstore;
  logic  halt;

  word_t       mem [256];  // unified instruction and data memory of 1 KB
  int          load_ptr;
  string       cur_test;
  int          test_errors;
  int          total_errors;
  int          assert_base;
  int          checks;
  int          passed;
  int          failed;

  // memory model state
  logic        i_active;
  word_t       i_addr;
  int          i_wait;
  logic        d_active;
  logic [65:0] d_key;
  int          d_wait;
  logic        d_commit;
  logic [7:0]  d_idx;
  word_t       d_data;

  cpu_core dut_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .imemload  (imemload),
    .ihit      (ihit),
    .dmemload  (dmemload),
    .dhit      (dhit),
    .imemREN   (imemREN),
    .imemaddr  (imemaddr),
    .dmemREN   (dmemREN),
    .dmemWEN   (dmemWEN),
    .dmemaddr  (dmemaddr),
    .dmemstore (dmemstore),
    .halt      (halt)
  );

  initial CLK = 1'b0;
  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // ------------------------------------------------------------
  // memory model hits each new request after 0 to 3 cycles
  // ------------------------------------------------------------
  initial begin
    void'($urandom(SEED));
    imemload = '0;
    ihit     = 1'b0;
    dmemload = '0;
    dhit     = 1'b0;
    i_active = 1'b0;
    d_active = 1'b0;
    d_commit = 1'b0;
    forever begin
      @(posedge CLK);
      #1;
      if (d_commit) begin
        mem[d_idx] = d_data;  // store accepted on the last edge
      end
      d_commit = 1'b0;
      if (!imemREN) begin
        ihit     = 1'b0;
        i_active = 1'b0;
      end else if (!i_active || (imemaddr != i_addr)) begin
        i_active = 1'b1;
        i_addr   = imemaddr;
        i_wait   = $urandom % 4;
        ihit     = (i_wait == 0);
      end else if (!ihit) begin
        i_wait = i_wait - 1;
        ihit   = (i_wait == 0);
      end
      imemload = mem[imemaddr[9:2]];
      if (!(dmemREN || dmemWEN)) begin
        dhit     = 1'b0;
        d_active = 1'b0;
      end else if (!d_active || (d_key != {dmemREN, dmemWEN, dmemaddr, dmemstore})) begin
        d_active = 1'b1;
        d_key    = {dmemREN, dmemWEN, dmemaddr, dmemstore};
        d_wait   = $urandom % 4;
        dhit     = (d_wait == 0);
      end else if (!dhit) begin
        d_wait = d_wait - 1;
        dhit   = (d_wait == 0);
      end
      dmemload = mem[dmemaddr[9:2]];
      if (dmemWEN && dhit) begin
        d_commit = 1'b1;
        d_idx    = dmemaddr[9:2];
        d_data   = dmemstore;
      end
    end
  end

  initial begin
    #(CLK_PERIOD * CYCLES_PER_TEST * N_TESTS);
    $display("watchdog: run not finished after %0d cycles, stuck in %s",
             CYCLES_PER_TEST * N_TESTS, cur_test);
    $display("SIMULATION FAILED");
    $finish;
  end

  // ------------------------------------------------------------
  // program building and run control
  // ------------------------------------------------------------
  function automatic word_t fill_value(int unsigned idx);
    return 32'hface_0000 ^ (idx << 2);  // top bits decode as a bubble
  endfunction

  function automatic word_t r_instr(funct_t fn, regbits_t rs, regbits_t rt, regbits_t rd);
    return {RTYPE, rs, rt, rd, 5'b00000, fn};
  endfunction

  function automatic word_t i_instr(opcode_t op, regbits_t rs, regbits_t rt,
                                    logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t j_instr(opcode_t op, logic [25:0] index);
    return {op, index};
  endfunction

  function automatic word_t peek(word_t addr);
    return mem[addr[9:2]];
  endfunction

  task automatic emit(input word_t w);
    mem[load_ptr] = w;
    load_ptr++;
  endtask

  // core held in reset while the new program goes in
  task automatic hold_reset(input string name);
    cur_test    = name;
    test_errors = 0;
    @(posedge CLK);
    #1;
    nRST = 1'b0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_value(i);
    end
    load_ptr = 0;
  endtask

  task automatic run_program();
    repeat (2) @(posedge CLK);
    #1;
    nRST = 1'b1;
    do begin
      @(posedge CLK);
      #1;
    end while (halt !== 1'b1);
    repeat (3) @(posedge CLK);  // let the last store land
    #1;
  endtask

  task automatic check_word(input string what, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
      test_errors++;
      $display("** Error: %s %s: expected 0x%h, actual 0x%h",
               cur_test, what, expected, actual);
    end
  endtask

  task automatic check_flag(input string what, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      test_errors++;
      $display("** Error: %s %s: expected %b, actual %b", cur_test, what, expected, actual);
    end
  endtask

  task automatic report_test();
    test_errors  += dut_i.u_asserts.fail_count - assert_base;
    assert_base   = dut_i.u_asserts.fail_count;
    total_errors += test_errors;
    if (test_errors == 0) begin
      passed++;
      $display("%-22s ok", cur_test);
    end else begin
      failed++;
      $display("%-22s %0d mismatches", cur_test, test_errors);
    end
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic alu_forwarding_chain();
    word_t a;
    word_t b;
    word_t c;
    word_t d;
    word_t e;
    word_t f;
    hold_reset("alu_forwarding_chain");
    emit(i_instr(ADDIU, 0, 1, 16'h002d));
    emit(i_instr(ADDIU, 1, 2, 16'h001c));  // rs from memory stage
    emit(r_instr(ADDU, 1, 2, 3));          // rs from writeback and rt from memory
    emit(r_instr(SUBU, 3, 1, 4));
    emit(r_instr(AND, 4, 3, 5));
    emit(r_instr(OR, 5, 2, 6));
    emit(i_instr(ADDIU, 0, 7, 16'hfffd));  // -3
    emit(r_instr(SLT, 7, 6, 8));
    emit(r_instr(SLT, 6, 7, 9));
    emit(i_instr(SW, 0, 3, 16'h0100));
    emit(i_instr(SW, 0, 4, 16'h0104));
    emit(i_instr(SW, 0, 5, 16'h0108));
    emit(i_instr(SW, 0, 6, 16'h010c));
    emit(i_instr(SW, 0, 8, 16'h0110));
    emit(i_instr(SW, 0, 9, 16'h0114));
    emit(j_instr(HALT, '0));
    run_program();
    a = 32'h2d;
    b = a + 32'h1c;
    c = a + b;
    d = c - a;
    e = d & c;
    f = e | b;
    check_word("addu", c, peek(32'h100));
    check_word("subu", d, peek(32'h104));
    check_word("and", e, peek(32'h108));
    check_word("or", f, peek(32'h10c));
    // r6 holds a small positive value
    check_word("slt neg<pos", 32'd1, peek(32'h110));
    check_word("slt pos<neg", 32'd0, peek(32'h114));
    report_test();
  endtask

  task automatic load_use_stall();
    word_t loaded;
    word_t k;
    hold_reset("load_use_stall");
    loaded = 32'h0000_1111;
    k      = 32'h0000_0222;
    mem[32'h120 >> 2] = loaded;
    emit(i_instr(ADDIU, 0, 1, k[15:0]));
    emit(i_instr(LW, 0, 2, 16'h0120));
    emit(r_instr(ADDU, 2, 1, 3));  // needs r2 straight after the load
    emit(i_instr(SW, 0, 3, 16'h0124));
    emit(i_instr(LW, 0, 4, 16'h0124));
    emit(r_instr(SUBU, 4, 2, 5));
    emit(i_instr(SW, 0, 5, 16'h0128));
    emit(j_instr(HALT, '0));
    run_program();
    check_word("load plus reg", loaded + k, peek(32'h124));
    check_word("reload minus load", k, peek(32'h128));
    report_test();
  endtask

  task automatic branch_paths();
    word_t mark;
    hold_reset("branch_paths");
    mark = 32'h0000_00aa;
    emit(i_instr(ADDIU, 0, 1, 16'd7));
    emit(i_instr(ADDIU, 0, 2, 16'd7));
    emit(i_instr(ADDIU, 0, 3, 16'd9));
    emit(i_instr(ADDIU, 0, 9, mark[15:0]));
    emit(i_instr(BEQ, 1, 2, 16'd2));     // taken
    emit(i_instr(SW, 0, 9, 16'h0140));   // wrong path
    emit(i_instr(SW, 0, 9, 16'h0144));   // wrong path
    emit(i_instr(BEQ, 1, 3, 16'd1));     // falls through
    emit(i_instr(SW, 0, 9, 16'h0148));
    emit(i_instr(BNE, 1, 3, 16'd1));     // taken
    emit(i_instr(SW, 0, 9, 16'h014c));   // wrong path
    emit(i_instr(BNE, 1, 2, 16'd1));     // falls through
    emit(i_instr(SW, 0, 9, 16'h0150));
    emit(j_instr(HALT, '0));
    run_program();
    check_word("beq taken skip 1", fill_value(32'h140 >> 2), peek(32'h140));
    check_word("beq taken skip 2", fill_value(32'h144 >> 2), peek(32'h144));
    check_word("beq not taken", mark, peek(32'h148));
    check_word("bne taken skip", fill_value(32'h14c >> 2), peek(32'h14c));
    check_word("bne not taken", mark, peek(32'h150));
    report_test();
  endtask

  task automatic jump_and_link();
    word_t jal_pc;
    hold_reset("jump_and_link");
    jal_pc = 32'd16;
    emit(i_instr(ADDIU, 0, 5, 16'h0055));
    emit(j_instr(J, 26'd4));
    emit(i_instr(SW, 0, 5, 16'h0160));   // skipped
    emit(i_instr(SW, 0, 5, 16'h0164));   // skipped
    emit(j_instr(JAL, 26'd8));           // at byte 16
    emit(i_instr(SW, 0, 31, 16'h0168));  // return lands here
    emit(j_instr(HALT, '0));
    emit(i_instr(SW, 0, 5, 16'h016c));   // behind halt
    emit(i_instr(ADDIU, 0, 6, 16'h0066));
    emit(i_instr(SW, 0, 6, 16'h0170));
    emit(r_instr(JR, 31, 0, 0));
    emit(i_instr(SW, 0, 5, 16'h0174));   // skipped
    emit(j_instr(HALT, '0));
    run_program();
    check_word("r31 after jal", jal_pc + 4, peek(32'h168));
    check_word("subroutine store", 32'h66, peek(32'h170));
    check_word("j skip 1", fill_value(32'h160 >> 2), peek(32'h160));
    check_word("j skip 2", fill_value(32'h164 >> 2), peek(32'h164));
    check_word("after halt", fill_value(32'h16c >> 2), peek(32'h16c));
    check_word("jr skip", fill_value(32'h174 >> 2), peek(32'h174));
    report_test();
  endtask

  task automatic upper_constant();
    hold_reset("upper_constant");
    emit(i_instr(LUI, 0, 1, 16'hdead));
    emit(i_instr(ORI, 1, 1, 16'hbeef));
    emit(i_instr(ADDIU, 0, 0, 16'h0077));  // r0 write dropped
    emit(r_instr(ADDU, 0, 0, 2));          // no forward from r0
    emit(i_instr(ORI, 1, 0, 16'h0001));
    emit(r_instr(OR, 0, 0, 3));
    emit(i_instr(LUI, 0, 4, 16'h1234));
    emit(i_instr(ORI, 4, 4, 16'h8765));    // zero extended
    emit(i_instr(SW, 0, 1, 16'h0180));
    emit(i_instr(SW, 0, 2, 16'h0184));
    emit(i_instr(SW, 0, 3, 16'h0188));
    emit(i_instr(SW, 0, 0, 16'h018c));
    emit(i_instr(SW, 0, 4, 16'h0190));
    emit(j_instr(HALT, '0));
    run_program();
    check_word("lui ori", 32'hdead_beef, peek(32'h180));
    check_word("r0 after addiu", '0, peek(32'h184));
    check_word("r0 after ori", '0, peek(32'h188));
    check_word("r0 stored", '0, peek(32'h18c));
    check_word("ori bit 15", 32'h1234_8765, peek(32'h190));
    report_test();
  endtask

  task automatic halt_sticky();
    hold_reset("halt_sticky");
    emit(i_instr(ADDIU, 0, 1, 16'h003c));
    emit(i_instr(SW, 0, 1, 16'h01a0));
    emit(j_instr(HALT, '0));
    emit(i_instr(SW, 0, 1, 16'h01a4));
    emit(i_instr(SW, 0, 1, 16'h01a8));
    emit(i_instr(ADDIU, 0, 2, 16'h0001));
    emit(i_instr(SW, 0, 2, 16'h01a0));   // would overwrite
    run_program();
    repeat (20) begin
      @(posedge CLK);
      #1;
      check_flag("halt held", 1'b1, halt);
      check_flag("imemREN idle", 1'b0, imemREN);
      check_flag("dmem idle", 1'b0, dmemREN | dmemWEN);
    end
    check_word("store before halt", 32'h3c, peek(32'h1a0));
    check_word("store after halt 1", fill_value(32'h1a4 >> 2), peek(32'h1a4));
    check_word("store after halt 2", fill_value(32'h1a8 >> 2), peek(32'h1a8));
    report_test();
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    nRST         = 1'b0;
    total_errors = 0;
    assert_base  = 0;
    checks       = 0;
    passed       = 0;
    failed       = 0;
    cur_test     = "startup";
    alu_forwarding_chain();
    load_use_stall();
    branch_paths();
    jump_and_link();
    upper_constant();
    halt_sticky();
    $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
             passed + failed, passed, failed, checks, total_errors);
    if (total_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+.
cpu_types_pkg.sv
register_file_if.sv
register_file.sv
alu.sv
control_unit.sv
hazard_unit.sv
datapath.sv
cpu_core.sv
cpu_asserts.sv
cpu_tb.sv
